//--- icache_pkg.sv
// cache geometry constants, vector typedefs and refill state encoding
package icache_pkg;

  // 4-way set associative, four instruction words per line
  localparam int num_ways    = 4;
  localparam int block_words = 4;

  // byte offset bits within one line, word select included
  localparam int offset_bits = 4;

  // byte address, fetch address is physical
  typedef logic [31:0] addr_t;

  // one instruction word
  typedef logic [31:0] instr_t;

  // way number and one-bit-per-way mask
  typedef logic [1:0] way_t;
  typedef logic [3:0] way_mask_t;

  // word within a line, address bits 3 to 2
  typedef logic [1:0] word_sel_t;

  // pseudo-LRU tree bits of one set
  // bit 0 picks the half, bit 1 picks within ways 0/1, bit 2 within ways 2/3
  typedef logic [2:0] plru_t;

  // refill engine states
  typedef enum logic [1:0] {
    idle,
    fetch,
    done
  } refill_state_e;

endpackage

//--- icache_fetch_stage.sv
// fetch stage: request acceptance, array read issue, held lookup address
`timescale 1ns/100ps

module icache_fetch_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_v_i,
  input  icache_pkg::addr_t req_addr_i,
  output logic              req_ready_o,
  input  logic              miss_i,
  input  logic              fill_done_i,
  output logic              rd_en_o,
  output icache_pkg::addr_t rd_addr_o,
  output logic              stage_v_o,
  output icache_pkg::addr_t stage_addr_o
);

  logic              accept;
  logic              stage_v_r;
  icache_pkg::addr_t stage_addr_r;

  // a pending miss blocks new requests
  assign req_ready_o = ~miss_i;
  assign accept      = req_v_i & req_ready_o;

  // new request read or replay of the held address after a fill
  assign rd_en_o   = accept | fill_done_i;
  assign rd_addr_o = fill_done_i ? stage_addr_r : req_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_v_r <= 1'b0;
    end else if (!miss_i) begin
      stage_v_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_addr_r <= req_addr_i;
    end
  end

  assign stage_v_o    = stage_v_r;
  assign stage_addr_o = stage_addr_r;

  // the held fetch keeps ready low until its refill hands back the replay
  a_miss_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_i && !fill_done_i) |=> miss_i)
    else $error("miss dropped before its refill finished");

endmodule

//--- icache_tag_array.sv
// tag array: per-way tag memories with synchronous read, resettable valid bits
`timescale 1ns/100ps

module icache_tag_array #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p),
  localparam int tag_w   = $bits(icache_pkg::addr_t) - icache_pkg::offset_bits - index_w
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     rd_en_i,
  input  icache_pkg::addr_t                        rd_addr_i,
  input  logic                                     wr_en_i,
  input  icache_pkg::way_t                         wr_way_i,
  input  icache_pkg::addr_t                        wr_addr_i,
  output logic [icache_pkg::num_ways-1:0][tag_w-1:0] tags_o,
  output icache_pkg::way_mask_t                    valid_o
);

  logic [index_w-1:0] rd_index;
  logic [index_w-1:0] wr_index;
  logic [tag_w-1:0]   wr_tag;

  logic [tag_w-1:0]      tag_mem [icache_pkg::num_ways][sets_p];
  icache_pkg::way_mask_t valid_r [sets_p];

  assign rd_index = rd_addr_i[icache_pkg::offset_bits +: index_w];
  assign wr_index = wr_addr_i[icache_pkg::offset_bits +: index_w];
  assign wr_tag   = wr_addr_i[icache_pkg::offset_bits + index_w +: tag_w];

  // tag storage and its read port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_way_i][wr_index] <= wr_tag;
    end
    if (rd_en_i) begin
      for (int w = 0; w < icache_pkg::num_ways; w++) begin
        tags_o[w] <= tag_mem[w][rd_index];
      end
    end
  end

  // valid bits live in flops so reset can clear the whole cache
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
      end
      valid_o <= '0;
    end else begin
      if (wr_en_i) begin
        valid_r[wr_index][wr_way_i] <= 1'b1;
      end
      if (rd_en_i) begin
        valid_o <= valid_r[rd_index];
      end
    end
  end

endmodule

//--- icache_data_array.sv
// data array: one instruction-word bank per way, synchronous read, word write
`timescale 1ns/100ps

module icache_data_array #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p),
  localparam int word_w  = $bits(icache_pkg::word_sel_t),
  localparam int depth   = sets_p * icache_pkg::block_words
) (
  input  logic                                         clk_i,
  input  logic                                         rd_en_i,
  input  icache_pkg::addr_t                            rd_addr_i,
  input  logic                                         wr_en_i,
  input  icache_pkg::way_t                             wr_way_i,
  input  icache_pkg::addr_t                            wr_addr_i,
  input  icache_pkg::instr_t                           wr_data_i,
  output icache_pkg::instr_t [icache_pkg::num_ways-1:0] rd_data_o
);

  logic [index_w+word_w-1:0] rd_word;
  logic [index_w+word_w-1:0] wr_word;

  // bank address is {index, word select}
  assign rd_word = rd_addr_i[2 +: index_w + word_w];
  assign wr_word = wr_addr_i[2 +: index_w + word_w];

  for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : g_bank
    icache_pkg::instr_t mem [depth];

    always_ff @(posedge clk_i) begin
      if (wr_en_i && wr_way_i == icache_pkg::way_t'(w)) begin
        mem[wr_word] <= wr_data_i;
      end
      // same word from every way, lookup picks the hit one
      if (rd_en_i) begin
        rd_data_o[w] <= mem[rd_word];
      end
    end
  end

endmodule

//--- icache_lookup.sv
// lookup: tag compare, hit way encode, instruction select, miss detection
`timescale 1ns/100ps

module icache_lookup #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p),
  localparam int tag_w   = $bits(icache_pkg::addr_t) - icache_pkg::offset_bits - index_w
) (
  input  logic                                         stage_v_i,
  input  icache_pkg::addr_t                            stage_addr_i,
  input  logic [icache_pkg::num_ways-1:0][tag_w-1:0]   tags_i,
  input  icache_pkg::way_mask_t                        valid_i,
  input  icache_pkg::instr_t [icache_pkg::num_ways-1:0] rd_data_i,
  output logic                                         resp_v_o,
  output icache_pkg::instr_t                           resp_instr_o,
  output logic                                         miss_o,
  output logic                                         hit_v_o,
  output icache_pkg::way_t                             hit_way_o
);

  logic [tag_w-1:0]      stage_tag;
  icache_pkg::way_mask_t hit_mask;
  icache_pkg::way_t      hit_way;
  logic                  any_hit;

  assign stage_tag = stage_addr_i[icache_pkg::offset_bits + index_w +: tag_w];

  always_comb begin
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      hit_mask[w] = valid_i[w] && (tags_i[w] == stage_tag);
    end
  end

  // one-hot to binary
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      if (hit_mask[w]) begin
        hit_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign any_hit = |hit_mask;

  assign hit_v_o      = stage_v_i & any_hit;
  assign hit_way_o    = hit_way;
  assign miss_o       = stage_v_i & ~any_hit;
  assign resp_v_o     = hit_v_o;
  assign resp_instr_o = rd_data_i[hit_way];

  // two hitting ways would mean the refill installed a line that was already present
  a_one_hit: assert final (!stage_v_i || $onehot0(hit_mask))
    else $error("more than one way hits");

endmodule

//--- icache_plru.sv
// pseudo-LRU: per-set tree bits, update on hit and fill, victim selection
`timescale 1ns/100ps

module icache_plru #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p)
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  icache_pkg::addr_t     addr_i,
  input  icache_pkg::way_mask_t valid_i,
  input  logic                  hit_v_i,
  input  icache_pkg::way_t      hit_way_i,
  input  logic                  fill_v_i,
  input  icache_pkg::way_t      fill_way_i,
  input  icache_pkg::addr_t     fill_addr_i,
  output icache_pkg::way_t      victim_o
);

  logic [index_w-1:0] index;
  logic [index_w-1:0] fill_index;
  icache_pkg::plru_t  tree;
  icache_pkg::plru_t  tree_r [sets_p];

  // point the tree away from the way just used
  function automatic icache_pkg::plru_t touch(icache_pkg::plru_t bits, icache_pkg::way_t w);
    icache_pkg::plru_t nxt;
    nxt    = bits;
    nxt[0] = ~w[1];
    if (w[1]) begin
      nxt[2] = ~w[0];
    end else begin
      nxt[1] = ~w[0];
    end
    return nxt;
  endfunction

  assign index      = addr_i[icache_pkg::offset_bits +: index_w];
  assign fill_index = fill_addr_i[icache_pkg::offset_bits +: index_w];
  assign tree       = tree_r[index];

  // invalid ways first, lowest number wins
  always_comb begin
    victim_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        victim_o = icache_pkg::way_t'(w);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        tree_r[s] <= '0;
      end
    end else if (fill_v_i) begin
      tree_r[fill_index] <= touch(tree_r[fill_index], fill_way_i);
    end else if (hit_v_i) begin
      tree_r[index] <= touch(tree, hit_way_i);
    end
  end

endmodule

//--- icache_refill.sv
// refill engine: Wishbone classic read master that fetches a line into the arrays
`timescale 1ns/100ps

module icache_refill #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p),
  localparam int tag_w   = $bits(icache_pkg::addr_t) - icache_pkg::offset_bits - index_w
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               miss_i,
  input  icache_pkg::addr_t  miss_addr_i,
  input  icache_pkg::way_t   victim_i,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output icache_pkg::addr_t  wb_adr_o,
  input  icache_pkg::instr_t wb_dat_i,
  input  logic               wb_ack_i,
  output logic               data_wr_en_o,
  output logic               tag_wr_en_o,
  output icache_pkg::way_t   wr_way_o,
  output icache_pkg::addr_t  wr_addr_o,
  output icache_pkg::instr_t wr_data_o,
  output logic               fill_done_o
);

  icache_pkg::refill_state_e state_r;
  icache_pkg::word_sel_t     word_r;
  icache_pkg::way_t          way_r;
  logic [tag_w-1:0]          tag_r;
  logic [index_w-1:0]        index_r;
  logic                      word_ack;
  logic                      last_ack;

  // one bus cycle per line with the strobe held up until each ack
  assign wb_cyc_o = (state_r == icache_pkg::fetch);
  assign wb_stb_o = wb_cyc_o;
  assign wb_adr_o = {tag_r, index_r, word_r, 2'b00};

  assign word_ack = wb_stb_o & wb_ack_i;
  assign last_ack = word_ack &&
                    (word_r == icache_pkg::word_sel_t'(icache_pkg::block_words - 1));

  // each acked word goes straight into the data array
  assign data_wr_en_o = word_ack;
  assign wr_addr_o    = wb_adr_o;
  assign wr_data_o    = wb_dat_i;
  assign wr_way_o     = way_r;

  // tag and valid go in with the last word so the line is never half visible
  assign tag_wr_en_o = last_ack;
  assign fill_done_o = (state_r == icache_pkg::done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= icache_pkg::idle;
      word_r  <= '0;
    end else begin
      case (state_r)
        icache_pkg::idle: begin
          if (miss_i) begin
            word_r  <= '0;
            state_r <= icache_pkg::fetch;
          end
        end
        icache_pkg::fetch: begin
          if (word_ack) begin
            word_r <= word_r + 1'b1;
          end
          if (last_ack) begin
            state_r <= icache_pkg::done;
          end
        end
        icache_pkg::done: begin
          state_r <= icache_pkg::idle;
        end
        default: begin
          state_r <= icache_pkg::idle;
        end
      endcase
    end
  end

  // line address and victim captured once per miss
  always_ff @(posedge clk_i) begin
    if (state_r == icache_pkg::idle && miss_i) begin
      tag_r   <= miss_addr_i[icache_pkg::offset_bits + index_w +: tag_w];
      index_r <= miss_addr_i[icache_pkg::offset_bits +: index_w];
      way_r   <= victim_i;
    end
  end

  // the slave may only ack a strobe of this master
  a_ack_in_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_i |-> (wb_stb_o && wb_cyc_o))
    else $error("Wishbone ack outside a strobe");

endmodule

//--- icache_top.sv
// instruction cache top level: fetch stage, arrays, lookup, pseudo-LRU and refill
`timescale 1ns/100ps

module icache_top #(
  parameter  int sets_p  = 16,
  localparam int index_w = $clog2(sets_p),
  localparam int tag_w   = $bits(icache_pkg::addr_t) - icache_pkg::offset_bits - index_w
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_v_i,
  input  icache_pkg::addr_t  req_addr_i,
  output logic               req_ready_o,
  output logic               resp_v_o,
  output icache_pkg::instr_t resp_instr_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output icache_pkg::addr_t  wb_adr_o,
  input  icache_pkg::instr_t wb_dat_i,
  input  logic               wb_ack_i
);

  logic                                         rd_en;
  icache_pkg::addr_t                            rd_addr;
  logic                                         stage_v;
  icache_pkg::addr_t                            stage_addr;
  logic [icache_pkg::num_ways-1:0][tag_w-1:0]   tags;
  icache_pkg::way_mask_t                        valid;
  icache_pkg::instr_t [icache_pkg::num_ways-1:0] rd_data;
  logic                                         miss;
  logic                                         hit_v;
  icache_pkg::way_t                             hit_way;
  icache_pkg::way_t                             victim;
  logic                                         data_wr_en;
  logic                                         tag_wr_en;
  icache_pkg::way_t                             wr_way;
  icache_pkg::addr_t                            wr_addr;
  icache_pkg::instr_t                           wr_data;
  logic                                         fill_done;

  icache_fetch_stage fetch_stage (
    .clk_i, .reset_i, .req_v_i, .req_addr_i, .req_ready_o,
    .miss_i(miss), .fill_done_i(fill_done),
    .rd_en_o(rd_en), .rd_addr_o(rd_addr),
    .stage_v_o(stage_v), .stage_addr_o(stage_addr)
  );

  icache_tag_array #(.sets_p(sets_p)) tag_array (
    .clk_i, .reset_i, .rd_en_i(rd_en), .rd_addr_i(rd_addr),
    .wr_en_i(tag_wr_en), .wr_way_i(wr_way), .wr_addr_i(wr_addr),
    .tags_o(tags), .valid_o(valid)
  );

  icache_data_array #(.sets_p(sets_p)) data_array (
    .clk_i, .rd_en_i(rd_en), .rd_addr_i(rd_addr),
    .wr_en_i(data_wr_en), .wr_way_i(wr_way), .wr_addr_i(wr_addr),
    .wr_data_i(wr_data), .rd_data_o(rd_data)
  );

  icache_lookup #(.sets_p(sets_p)) lookup (
    .stage_v_i(stage_v), .stage_addr_i(stage_addr), .tags_i(tags),
    .valid_i(valid), .rd_data_i(rd_data), .resp_v_o, .resp_instr_o,
    .miss_o(miss), .hit_v_o(hit_v), .hit_way_o(hit_way)
  );

  // fill update comes from the tag write of the last refill word
  icache_plru #(.sets_p(sets_p)) plru (
    .clk_i, .reset_i, .addr_i(stage_addr), .valid_i(valid),
    .hit_v_i(hit_v), .hit_way_i(hit_way),
    .fill_v_i(tag_wr_en), .fill_way_i(wr_way), .fill_addr_i(wr_addr),
    .victim_o(victim)
  );

  icache_refill #(.sets_p(sets_p)) refill (
    .clk_i, .reset_i, .miss_i(miss), .miss_addr_i(stage_addr), .victim_i(victim),
    .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i,
    .data_wr_en_o(data_wr_en), .tag_wr_en_o(tag_wr_en), .wr_way_o(wr_way),
    .wr_addr_o(wr_addr), .wr_data_o(wr_data), .fill_done_o(fill_done)
  );

endmodule

//--- icache_tb_memory.sv
// Wishbone slave memory model: fixed word pattern, random wait states, acked address log
`timescale 1ns/100ps

module icache_tb_memory (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  icache_pkg::addr_t  wb_adr_i,
  output icache_pkg::instr_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               log_v_o,
  output icache_pkg::addr_t  log_adr_o
);

  logic [1:0] waited;
  logic [1:0] wait_target;

  // memory contents as a function of the whole address
  function automatic icache_pkg::instr_t mem_word(input icache_pkg::addr_t a);
    icache_pkg::instr_t x;
    x = a ^ 32'h5a5a0000;
    return {x[24:0], x[31:25]};
  endfunction

  assign wb_dat_o = mem_word(wb_adr_i);

  // ack once the drawn number of wait states has passed
  assign wb_ack_o = wb_cyc_i & wb_stb_i & (waited == wait_target);

  always @(posedge clk_i) begin
    if (reset_i) begin
      waited      <= '0;
      wait_target <= 2'($urandom % 4);
      log_v_o     <= 1'b0;
    end else begin
      log_v_o <= wb_ack_o;
      if (wb_ack_o) begin
        waited      <= '0;
        wait_target <= 2'($urandom % 4);
        log_adr_o   <= wb_adr_i;
      end else if (wb_cyc_i && wb_stb_i) begin
        waited <= waited + 1'b1;
      end
    end
  end

endmodule

//--- icache_tb.sv
// testbench top: clock, reset, stimulus, reference model, response checks and watchdog
`timescale 1ns/100ps

module icache_tb;

  localparam int sets_p  = 16;
  localparam int index_w = $clog2(sets_p);
  localparam int tag_w   = 32 - icache_pkg::offset_bits - index_w;
  // requests over all six tests
  localparam int total_requests = 71;

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               req_v_i;
  icache_pkg::addr_t  req_addr_i;
  logic               req_ready_o;
  logic               resp_v_o;
  icache_pkg::instr_t resp_instr_o;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_ack;
  icache_pkg::addr_t  wb_adr;
  icache_pkg::instr_t wb_dat;
  logic               log_v;
  icache_pkg::addr_t  log_adr;

  // reference model state, one entry per set
  logic [tag_w-1:0]      ref_tag [sets_p][icache_pkg::num_ways];
  icache_pkg::way_mask_t ref_valid [sets_p];
  icache_pkg::plru_t     ref_tree [sets_p];
  icache_pkg::addr_t     evicted_line;
  icache_pkg::instr_t    exp_q [$];
  icache_pkg::addr_t     adr_q [$];
  icache_pkg::addr_t     set_lines [5];
  icache_pkg::addr_t     reload;

  int   errors = 0;
  int   checks = 0;
  int   tests = 0;
  int   acks = 0;
  int   ref_misses = 0;
  int   errors_at_start;
  int   misses_at_start;
  int   acks_at_start;
  logic ready_low = 1'b0;

  icache_top #(.sets_p(sets_p)) uut (
    .clk_i, .reset_i, .req_v_i, .req_addr_i, .req_ready_o, .resp_v_o, .resp_instr_o,
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr), .wb_dat_i(wb_dat),
    .wb_ack_i(wb_ack)
  );

  icache_tb_memory memory (
    .clk_i, .reset_i, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_adr_i(wb_adr),
    .wb_dat_o(wb_dat), .wb_ack_o(wb_ack), .log_v_o(log_v), .log_adr_o(log_adr)
  );

  always #50 clk_i = ~clk_i;

  // access to way w turns the tree away from it
  function automatic icache_pkg::plru_t point_away(input icache_pkg::plru_t t,
                                                   input icache_pkg::way_t w);
    icache_pkg::plru_t n;
    n = t;
    if (w < 2) begin
      n[0] = 1'b1;
      n[1] = (w == 0);
    end else begin
      n[0] = 1'b0;
      n[2] = (w == 2);
    end
    return n;
  endfunction

  function automatic icache_pkg::way_t pick_victim(input int s);
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      if (!ref_valid[s][w]) begin
        return icache_pkg::way_t'(w);
      end
    end
    if (!ref_tree[s][0]) begin
      return ref_tree[s][1] ? 2'd1 : 2'd0;
    end
    return ref_tree[s][2] ? 2'd3 : 2'd2;
  endfunction

  // expected instruction, and the refill reads on a miss
  function automatic icache_pkg::instr_t predict(input icache_pkg::addr_t addr);
    int               s;
    logic [tag_w-1:0] tag;
    icache_pkg::way_t way;
    logic             hit;
    s   = addr[icache_pkg::offset_bits +: index_w];
    tag = addr[31 -: tag_w];
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      if (ref_valid[s][w] && ref_tag[s][w] == tag) begin
        hit = 1'b1;
        way = icache_pkg::way_t'(w);
      end
    end
    if (!hit) begin
      way          = pick_victim(s);
      evicted_line = {ref_tag[s][way], addr[icache_pkg::offset_bits +: index_w], 4'h0};
      ref_valid[s][way] = 1'b1;
      ref_tag[s][way]   = tag;
      ref_misses++;
      for (int k = 0; k < icache_pkg::block_words; k++) begin
        adr_q.push_back({addr[31:4], 4'h0} + 4 * k);
      end
    end
    ref_tree[s] = point_away(ref_tree[s], way);
    return memory.mem_word({addr[31:2], 2'b00});
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_instr(input icache_pkg::instr_t got, input icache_pkg::instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: resp_instr_o = %08h, expected %08h", $time, got, exp);
    end
  endtask

  task automatic check_addr(input icache_pkg::addr_t got, input icache_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: wb_adr_o = %08h, expected %08h", $time, got, exp);
    end
  endtask

  // hold the request until a cycle with req_ready_o high
  task automatic issue(input icache_pkg::addr_t addr);
    logic taken;
    exp_q.push_back(predict(addr));
    req_v_i    = 1'b1;
    req_addr_i = addr;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #10;
    end
    req_v_i = 1'b0;
  endtask

  task automatic start_test();
    errors_at_start = errors;
    misses_at_start = ref_misses;
    acks_at_start   = acks;
  endtask

  task automatic finish_test(input string name);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    #10;
    if (acks - acks_at_start != 4 * (ref_misses - misses_at_start)) begin
      flag_error($sformatf("%s made %0d Wishbone reads, %0d refills expected", name,
                           acks - acks_at_start, ref_misses - misses_at_start));
    end
    tests++;
    $display("test %0d %s: %s", tests, name, errors == errors_at_start ? "ok" : "FAILED");
  endtask

  // responses and refill reads against the reference queues
  always @(negedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      if (exp_q.size() == 0) begin
        flag_error("response without an outstanding request");
      end else begin
        check_instr(resp_instr_o, exp_q.pop_front());
      end
    end
    if (!reset_i && log_v) begin
      acks++;
      if (adr_q.size() == 0) begin
        flag_error("Wishbone read without an expected refill");
      end else begin
        check_addr(log_adr, adr_q.pop_front());
      end
    end
  end

  // ready may only come back together with the response of the missing fetch
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (!req_ready_o) begin
        ready_low = 1'b1;
      end else if (ready_low) begin
        ready_low = 1'b0;
        if (!resp_v_o) begin
          flag_error("req_ready_o rose before the missing fetch returned");
        end
      end
    end
  end

  initial begin
    #(total_requests * 40 * 100);
    $display("watchdog expired, the DUT stopped responding");
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(30));
    reset_i    = 1'b1;
    req_v_i    = 1'b0;
    req_addr_i = '0;
    for (int s = 0; s < sets_p; s++) begin
      ref_valid[s] = '0;
      ref_tree[s]  = '0;
    end
    repeat (2) @(posedge clk_i);
    #10;
    reset_i = 1'b0;

    start_test();
    @(negedge clk_i);
    if (!req_ready_o || wb_cyc || wb_stb) begin
      flag_error("after reset req_ready_o is low or a Wishbone cycle is active");
    end
    @(posedge clk_i);
    #10;
    issue(32'h0000_1234);
    finish_test("first fetch refills");

    start_test();
    for (int i = 0; i < 8; i++) begin
      issue(32'h0000_1230 + ((i * 5) % 16));
    end
    finish_test("back-to-back hits");

    // four tags in set 5
    start_test();
    for (int i = 0; i < 5; i++) begin
      set_lines[i] = ((i + 1) << (4 + index_w)) | (5 << 4);
    end
    for (int i = 0; i < 8; i++) begin
      issue(set_lines[i % 4] + 4 * (i % 3));
    end
    finish_test("fill all four ways");

    start_test();
    issue(set_lines[3]);
    issue(set_lines[0] + 4);
    issue(set_lines[2] + 8);
    issue(set_lines[4] + 8);
    reload = evicted_line;
    issue(reload + 4);
    for (int i = 0; i < 5; i++) begin
      if (set_lines[i] != reload && set_lines[i] != evicted_line) begin
        issue(set_lines[i] + 12);
      end
    end
    finish_test("pseudo-LRU victim");

    start_test();
    for (int i = 0; i < 6; i++) begin
      issue(((i % 3 + 1) << (4 + index_w)) | (9 << 4) | ((i % 4) << 2));
    end
    finish_test("wait states and ready");

    start_test();
    for (int i = 0; i < 40; i++) begin
      issue((($urandom % 6) << (4 + index_w)) | (($urandom % 4) << 4) |
            (($urandom % 4) << 2) | ($urandom % 4));
      if ($urandom % 4 == 0) begin
        @(posedge clk_i);
        #10;
      end
    end
    finish_test("random mix");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- files.f
icache_pkg.sv
icache_fetch_stage.sv
icache_tag_array.sv
icache_data_array.sv
icache_lookup.sv
icache_plru.sv
icache_refill.sv
icache_top.sv
icache_tb_memory.sv
icache_tb.sv
